// File: regex_cfg.svh
`ifndef REGEX_CFG_SVH
`define REGEX_CFG_SVH

// Number of independent scan contexts kept in the store
`define REGEX_STREAMS 64

// Stream number carried with sop
`define REGEX_SID_W 6

// Matcher state, four states 0 to 3
`define REGEX_STATE_W 2

// Global hit counter
`define REGEX_COUNT_W 16

`endif

// File: regex_pkg.sv
`default_nettype none

`include "regex_cfg.svh"

package regex_pkg;

   // Encoded matcher state, saved per stream
   typedef logic [`REGEX_STATE_W-1:0] dfa_state_t;

   // Nothing of the pattern seen yet
   localparam dfa_state_t ST_NONE = 2'd0;
   // Seen "d"
   localparam dfa_state_t ST_D    = 2'd1;
   // Seen "dn"
   localparam dfa_state_t ST_DN   = 2'd2;
   // Full "dns" just seen
   localparam dfa_state_t ST_DNS  = 2'd3;

   // Hit counter value
   typedef logic [`REGEX_COUNT_W-1:0] hit_count_t;

   // Packet framing states of the controller
   typedef enum logic [1:0] {IDLE, LOAD, SCAN, COMMIT} pkt_state_t;

endpackage

`default_nettype wire

// File: scan_ctx_if.sv
`default_nettype none

`include "regex_cfg.svh"

interface scan_ctx_if import regex_pkg::*; ();

   // Controller strobes and latched packet attributes
   logic                    load_req;
   logic                    new_ctx;
   logic                    save_en;
   logic                    commit;
   logic                    scan_en;
   logic [`REGEX_SID_W-1:0] sid;
   // Payload bytes, already gated by scan_en
   logic [7:0]              char_byte;
   logic                    char_vld;
   // Store response
   dfa_state_t              restore_state;
   logic                    restore_vld;
   // Matcher output
   dfa_state_t              cur_state;
   logic                    accept;

   modport ctrl (output load_req, new_ctx, save_en, commit, scan_en, sid, char_byte, char_vld,
                 input restore_vld);
   modport store (input load_req, new_ctx, save_en, commit, sid, cur_state,
                  output restore_state, restore_vld);
   modport dfa (input char_byte, char_vld, restore_state, restore_vld,
                output cur_state, accept);
   // Read-only view for the hit counter
   modport mon (input load_req, save_en, commit, accept);

endinterface

`default_nettype wire

// File: pkt_ctrl_fsm.sv
`default_nettype none

`include "regex_cfg.svh"

module pkt_ctrl_fsm
   import regex_pkg::*;
(
   input wire                    clk,
   input wire                    rst_n,
   input wire                    sop,
   input wire [`REGEX_SID_W-1:0] stream_id,
   input wire                    new_stream,
   input wire                    enable,
   input wire [7:0]              char_in,
   input wire                    char_vld,
   input wire                    eop,
   scan_ctx_if.ctrl              ctx
);

   pkt_state_t state;
   pkt_state_t state_nxt;

   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:
         begin
            if (sop)
               state_nxt = LOAD;
         end
         // Wait here until the store hands back the stream context
         LOAD:
         begin
            if (ctx.restore_vld)
               state_nxt = SCAN;
         end
         SCAN:
         begin
            if (eop)
               state_nxt = COMMIT;
         end
         // Commit lasts exactly one cycle
         COMMIT:
            state_nxt = IDLE;
         default:
            state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state        <= IDLE;
         ctx.load_req <= 1'b0;
      end
      else
      begin
         state        <= state_nxt;
         // Single pulse in the first LOAD cycle
         ctx.load_req <= (state == IDLE) && sop;
      end
   end

   // Packet attributes held for the whole packet
   always_ff @(posedge clk)
   begin
      if ((state == IDLE) && sop)
      begin
         ctx.sid     <= stream_id;
         ctx.new_ctx <= new_stream;
         ctx.save_en <= enable;
      end
   end

   assign ctx.scan_en   = (state == SCAN);
   assign ctx.commit    = (state == COMMIT);
   // Bytes outside SCAN never reach the matcher
   assign ctx.char_vld  = char_vld && ctx.scan_en;
   assign ctx.char_byte = char_in;

   // A new packet may only start once the previous one is committed
   sop_in_idle: assert property (@(posedge clk) disable iff (!rst_n) sop |-> state == IDLE);

   // Environment keeps a gap between the last byte and eop
   eop_no_byte: assert property (@(posedge clk) disable iff (!rst_n) !(eop && char_vld));

endmodule

`default_nettype wire

// File: stream_ctx_store.sv
`default_nettype none

`include "regex_cfg.svh"

module stream_ctx_store
   import regex_pkg::*;
(
   input wire        clk,
   input wire        rst_n,
   scan_ctx_if.store ctx
);

   // One saved matcher state per stream
   dfa_state_t ctx_mem [`REGEX_STREAMS];

   // Restore path
   // New streams start from the cleared state and skip the memory
   always_ff @(posedge clk)
   begin
      if (ctx.load_req)
      begin
         if (ctx.new_ctx)
            ctx.restore_state <= ST_NONE;
         else
            ctx.restore_state <= ctx_mem[ctx.sid];
      end
   end

   // Valid follows load_req by one cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ctx.restore_vld <= 1'b0;
      else
         ctx.restore_vld <= ctx.load_req;
   end

   // Save path
   // Only enabled packets write back their final state
   always_ff @(posedge clk)
   begin
      if (ctx.commit && ctx.save_en)
         ctx_mem[ctx.sid] <= ctx.cur_state;
   end

   // Restore and save belong to different packet phases
   no_restore_at_commit: assert property (@(posedge clk) disable iff (!rst_n)
      !(ctx.restore_vld && ctx.commit));

endmodule

`default_nettype wire

// File: dns_dfa.sv
`default_nettype none

module dns_dfa
   import regex_pkg::*;
(
   input wire      clk,
   input wire      rst_n,
   scan_ctx_if.dfa ctx
);

   dfa_state_t step_state;

   // One transition of the "dns" matcher
   // Upper and lower case are folded by forcing bit 5 of the byte
   function automatic dfa_state_t dfa_step(dfa_state_t cur, logic [7:0] ch);
      logic [7:0] lc;
      dfa_state_t nxt;
      lc  = ch | 8'h20;
      nxt = ST_NONE;
      // A "d" always starts a fresh match
      if (lc == "d")
         nxt = ST_D;
      else
      begin
         case (cur)
            ST_D:
            begin
               if (lc == "n")
                  nxt = ST_DN;
            end
            ST_DN:
            begin
               if (lc == "s")
                  nxt = ST_DNS;
            end
            // From ST_DNS the search restarts
            default:
               nxt = ST_NONE;
         endcase
      end
      return nxt;
   endfunction

   assign step_state = dfa_step(ctx.cur_state, ctx.char_byte);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ctx.cur_state <= ST_NONE;
         ctx.accept    <= 1'b0;
      end
      // Restored context wins over any byte in the same cycle
      else if (ctx.restore_vld)
      begin
         ctx.cur_state <= ctx.restore_state;
         ctx.accept    <= 1'b0;
      end
      else if (ctx.char_vld)
      begin
         ctx.cur_state <= step_state;
         // Accept pulses for one cycle as the state reaches "dns"
         ctx.accept    <= (step_state == ST_DNS);
      end
      else
      begin
         ctx.accept    <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: match_counter.sv
`default_nettype none

module match_counter
   import regex_pkg::*;
(
   input wire         clk,
   input wire         rst_n,
   scan_ctx_if.mon    ctx,
   output hit_count_t count,
   output logic       fired
);

   // fired is the speculative per-packet match flag
   // It only turns into a count on an enabled commit
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired <= 1'b0;
      end
      else
      begin
         // New packet starts unmatched
         if (ctx.load_req)
            fired <= 1'b0;
         else if (ctx.accept)
            fired <= 1'b1;
         // Disabled packet drops its result
         else if (ctx.commit && !ctx.save_en)
            fired <= 1'b0;
      end
   end

   // One hit per packet however often the pattern occurs
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         count <= '0;
      else if (ctx.commit && ctx.save_en)
         count <= count + hit_count_t'(fired);
   end

   // Count only moves on the edge that ends a commit cycle
   count_at_commit: assert property (@(posedge clk) disable iff (!rst_n)
      !ctx.commit |=> $stable(count));

endmodule

`default_nettype wire

// File: regex_stream_top.sv
`default_nettype none

`include "regex_cfg.svh"

module regex_stream_top
   import regex_pkg::*;
(
   input wire                    clk,
   input wire                    rst_n,
   // Packet framing
   input wire                    sop,
   input wire [`REGEX_SID_W-1:0] stream_id,
   input wire                    new_stream,
   input wire                    enable,
   input wire                    eop,
   // Payload bytes
   input wire [7:0]              char_in,
   input wire                    char_vld,
   // Results
   output hit_count_t            count,
   output logic                  fired
);

   // Shared scan context bus between the four blocks
   scan_ctx_if ctx ();

   // Packet framing and strobe generation
   pkt_ctrl_fsm u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .stream_id  (stream_id),
      .new_stream (new_stream),
      .enable     (enable),
      .char_in    (char_in),
      .char_vld   (char_vld),
      .eop        (eop),
      .ctx        (ctx)
   );

   // Per-stream saved matcher state
   stream_ctx_store u_store (
      .clk   (clk),
      .rst_n (rst_n),
      .ctx   (ctx)
   );

   // Byte-wide "dns" matcher
   dns_dfa u_dfa (
      .clk   (clk),
      .rst_n (rst_n),
      .ctx   (ctx)
   );

   // Match flag and hit count
   match_counter u_count (
      .clk   (clk),
      .rst_n (rst_n),
      .ctx   (ctx),
      .count (count),
      .fired (fired)
   );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD       = 8,
   parameter int RESET_CYCLES = 8
)(
   output logic clk,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   // Free running clock
   initial
      clk = 1'b0;

   always
      #(PERIOD / 2) clk = ~clk;

   // Reset released shortly after an edge, like all other inputs
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// File: tb_regex_stream.sv
`default_nettype none

`include "regex_cfg.svh"

module tb_regex_stream import regex_pkg::*;;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 8;
   localparam int MAX_ROWS     = 16;
   localparam int MAX_GAP      = 3;
   localparam int unsigned SEED = 32'h5d54838c;

   // Reference encoding of the matcher progress
   localparam dfa_state_t REF_NONE = dfa_state_t'(0);
   localparam dfa_state_t REF_D    = dfa_state_t'(1);
   localparam dfa_state_t REF_DN   = dfa_state_t'(2);
   localparam dfa_state_t REF_DNS  = dfa_state_t'(3);

   logic                    clk;
   logic                    rst_n;
   logic                    sop;
   logic [`REGEX_SID_W-1:0] stream_id;
   logic                    new_stream;
   logic                    enable;
   logic                    eop;
   logic [7:0]              char_in;
   logic                    char_vld;
   hit_count_t              count;
   logic                    fired;

   // Stimulus table columns
   logic [`REGEX_SID_W-1:0] row_sid   [MAX_ROWS];
   logic                    row_new   [MAX_ROWS];
   logic                    row_en    [MAX_ROWS];
   string                   row_data  [MAX_ROWS];
   int                      row_gap   [MAX_ROWS];
   logic                    row_fired [MAX_ROWS];
   hit_count_t              row_count [MAX_ROWS];
   int                      n_rows = 0;

   // Reference model of the saved contexts and the global count
   dfa_state_t              ref_state [`REGEX_STREAMS];
   hit_count_t              ref_count;

   int                      errors = 0;
   int                      checks = 0;
   int                      watchdog_cycles = 0;
   bit                      table_ready = 1'b0;

   tb_clkgen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   regex_stream_top UUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .stream_id  (stream_id),
      .new_stream (new_stream),
      .enable     (enable),
      .eop        (eop),
      .char_in    (char_in),
      .char_vld   (char_vld),
      .count      (count),
      .fired      (fired)
   );

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
      end
   endtask

   // Step to just after the next rising edge
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic add_row(input logic [`REGEX_SID_W-1:0] sid, input logic is_new,
                          input logic en, input string data, input int gap,
                          input logic exp_fired, input hit_count_t exp_count);
      row_sid[n_rows]   = sid;
      row_new[n_rows]   = is_new;
      row_en[n_rows]    = en;
      row_data[n_rows]  = data;
      row_gap[n_rows]   = gap;
      row_fired[n_rows] = exp_fired;
      row_count[n_rows] = exp_count;
      n_rows++;
   endtask

   // Columns are sid, new, enable, payload, gap (-1 random), fired, count
   task automatic load_table();
      add_row(6'd1,  1'b1, 1'b1, "xxDnSyy",   0, 1'b1, 16'd1);
      add_row(6'd2,  1'b1, 1'b1, "dnsabcDNS", -1, 1'b1, 16'd2);
      // Split pattern, then the same split on a cleared stream
      add_row(6'd5,  1'b1, 1'b1, "xd",        1, 1'b0, 16'd2);
      add_row(6'd5,  1'b0, 1'b1, "ns",        0, 1'b1, 16'd3);
      add_row(6'd6,  1'b1, 1'b1, "xd",        0, 1'b0, 16'd3);
      add_row(6'd6,  1'b1, 1'b1, "ns",        2, 1'b0, 16'd3);
      // Disabled packet in between must not disturb stream 7
      add_row(6'd7,  1'b1, 1'b1, "ad",        0, 1'b0, 16'd3);
      add_row(6'd7,  1'b0, 1'b0, "ndns",      -1, 1'b1, 16'd3);
      add_row(6'd7,  1'b0, 1'b1, "ns",        0, 1'b1, 16'd4);
      // Interleaved partial matches
      add_row(6'd3,  1'b1, 1'b1, "d",         0, 1'b0, 16'd4);
      add_row(6'd9,  1'b1, 1'b1, "dn",        1, 1'b0, 16'd4);
      add_row(6'd3,  1'b0, 1'b1, "ns",        -1, 1'b1, 16'd5);
      add_row(6'd9,  1'b0, 1'b1, "q",         0, 1'b0, 16'd5);
      add_row(6'd12, 1'b1, 1'b1, "dnx s",     -1, 1'b0, 16'd5);
      add_row(6'd13, 1'b1, 1'b1, "DNDNSSD",   1, 1'b1, 16'd6);
      add_row(6'd13, 1'b0, 1'b1, "Ns",        0, 1'b1, 16'd7);
   endtask

   // One byte of the "dns" search, both cases accepted
   function automatic dfa_state_t ref_next(input dfa_state_t st, input logic [7:0] ch);
      if (ch == "d" || ch == "D")
         return REF_D;
      if (st == REF_D && (ch == "n" || ch == "N"))
         return REF_DN;
      if (st == REF_DN && (ch == "s" || ch == "S"))
         return REF_DNS;
      return REF_NONE;
   endfunction

   // Replays one row on the model and cross-checks the table columns
   task automatic run_model(input int r);
      string      data;
      dfa_state_t st;
      logic       matched;
      data    = row_data[r];
      matched = 1'b0;
      st      = row_new[r] ? REF_NONE : ref_state[row_sid[r]];
      for (int k = 0; k < data.len(); k++)
      begin
         st = ref_next(st, data[k]);
         if (st == REF_DNS)
            matched = 1'b1;
      end
      if (row_en[r])
      begin
         ref_state[row_sid[r]] = st;
         if (matched)
            ref_count = ref_count + hit_count_t'(1);
      end
      check_value($sformatf("table fired row %0d", r), 32'(row_fired[r]), 32'(matched));
      check_value($sformatf("table count row %0d", r), 32'(row_count[r]), 32'(ref_count));
   endtask

   task automatic send_packet(input int r);
      string data;
      int    gap;
      data       = row_data[r];
      sop        = 1'b1;
      stream_id  = row_sid[r];
      new_stream = row_new[r];
      enable     = row_en[r];
      next_cycle();
      sop        = 1'b0;
      new_stream = 1'b0;
      enable     = 1'b0;
      stream_id  = '0;
      // Context restore takes two more edges before SCAN
      repeat (2) next_cycle();
      for (int k = 0; k < data.len(); k++)
      begin
         gap = (row_gap[r] < 0) ? int'($urandom % (MAX_GAP + 1)) : row_gap[r];
         if (k > 0)
            repeat (gap) next_cycle();
         char_in  = data[k];
         char_vld = 1'b1;
         next_cycle();
         char_vld = 1'b0;
         char_in  = 8'h00;
      end
      // Accept lands one edge after the byte, fired one edge later
      next_cycle();
      check_value($sformatf("fired row %0d", r), 32'(fired), 32'(row_fired[r]));
      eop = 1'b1;
      next_cycle();
      eop = 1'b0;
      next_cycle();
      check_value($sformatf("count row %0d", r), 32'(count), 32'(row_count[r]));
      // A disabled commit drops the flag
      check_value($sformatf("fired after commit row %0d", r), 32'(fired),
                  32'(row_fired[r] & row_en[r]));
   endtask

   initial
   begin
      wait (table_ready);
      #(watchdog_cycles * CLK_PERIOD);
      $display("Timeout: run still busy after %0d clock cycles", watchdog_cycles);
      $display("TB FAILED");
      $finish;
   end

   initial
   begin
      sop        = 1'b0;
      stream_id  = '0;
      new_stream = 1'b0;
      enable     = 1'b0;
      eop        = 1'b0;
      char_in    = 8'h00;
      char_vld   = 1'b0;
      ref_count  = '0;
      for (int s = 0; s < `REGEX_STREAMS; s++)
         ref_state[s] = REF_NONE;
      void'($urandom(SEED));
      load_table();
      // Worst case per row with every gap at its maximum
      watchdog_cycles = RESET_CYCLES + 40;
      for (int r = 0; r < n_rows; r++)
         watchdog_cycles += 8 + row_data[r].len() * (MAX_GAP + 1);
      table_ready = 1'b1;
      wait (rst_n === 1'b1);
      next_cycle();
      check_value("count after reset", 32'(count), 32'h0);
      check_value("fired after reset", 32'(fired), 32'h0);
      for (int r = 0; r < n_rows; r++)
      begin
         run_model(r);
         send_packet(r);
      end
      repeat (2) next_cycle();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
regex_pkg.sv
scan_ctx_if.sv
pkt_ctrl_fsm.sv
stream_ctx_store.sv
dns_dfa.sv
match_counter.sv
regex_stream_top.sv
tb_clkgen.sv
tb_regex_stream.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_regex_stream
FLIST    = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = TB FAILED
PASS_MSG = TB PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The simulation status is taken from the log, not from the exit code
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
